//--- filelist.f
+incdir+logic
logic/eth_tx_pkg.sv
logic/axis_skid_reg.sv
logic/eth_hdr_serializer.sv
logic/eth_fcs_insert.sv
logic/eth_tx_path.sv
bench/tb_clock_gen.sv
bench/eth_tx_path_sva.sv
bench/tb_eth_tx_path.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/100ps
TOP      := tb_eth_tx_path
FILELIST := filelist.f
LOG      := sim.log
BIN      := obj_dir/V$(TOP)
SRCS     := $(shell grep -v '^+' $(FILELIST)) $(wildcard logic/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- bench/tb_eth_tx_path.sv
/* testbench for the ethernet tx path that builds frames, predicts the bytes on the wire
   and checks every output byte with random valid and ready stalls in the last test */
`timescale 1ns/100ps
`include "eth_tx_defines.svh"

module tb_eth_tx_path import eth_tx_pkg::*; ();

    logic       clk;
    logic       rst;
    eth_hdr_t   hdr;
    logic       hdr_valid;
    logic       hdr_ready;
    axis_byte_t s_payload;
    logic       s_payload_valid;
    logic       s_payload_ready;
    axis_byte_t m_frame;
    logic       m_frame_valid;
    logic       m_frame_ready;
    logic       busy;

    // frame table with the payload bytes of all frames back to back in pay_mem
    eth_hdr_t    f_hdr[$];
    int          f_len[$];
    logic        f_bad[$];
    int          f_start[$];
    logic [7:0]  pay_mem[$];
    axis_byte_t  exp_q[$];
    logic [15:0] lfsr_state;
    string       test_name;
    int          errors;
    int          checked;
    int          tests_failed;
    int          limit_cycles;
    int          err_mark;
    int          byte_mark;
    // bytes of the output frame in progress and length of the last finished one
    int          frame_bytes;
    int          last_frame_len;

    tb_clock_gen u_clk (.clk(clk), .rst(rst));

    eth_tx_path dut (.*);

    bind eth_tx_path eth_tx_path_sva u_sva (
        .clk(clk), .rst(rst), .s_payload(s_payload), .s_payload_valid(s_payload_valid),
        .s_payload_ready(s_payload_ready), .m_frame(m_frame), .m_frame_valid(m_frame_valid),
        .m_frame_ready(m_frame_ready), .busy(busy)
    );

    // 16-bit fibonacci lfsr with taps 16 14 13 11 and one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[15]};
            lfsr_state = {lfsr_state[14:0],
                          lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
        end
        return v;
    endfunction

    // bit-serial crc-32 with data lsb first
    function automatic logic [31:0] crc_update(input logic [31:0] c, input logic [7:0] d);
        logic [31:0] r;
        logic [7:0]  dd;
        logic        fb;
        r  = c;
        dd = d;
        for (int i = 0; i < 8; i++) begin
            fb = r[0] ^ dd[0];
            r  = r >> 1;
            dd = dd >> 1;
            if (fb) begin
                r = r ^ `ETH_CRC_POLY;
            end
        end
        return r;
    endfunction

    function automatic int wire_bytes(input int len);
        int n;
        n = `ETH_HDR_BYTES + len;
        if (n < `ETH_MIN_FRAME_BYTES) begin
            n = `ETH_MIN_FRAME_BYTES;
        end
        return n + `ETH_FCS_BYTES;
    endfunction

    // reference model that appends the expected wire bytes of one frame to exp_q
    function automatic void build_expected(input int idx);
        logic [7:0]   bytes[$];
        logic [111:0] hbits;
        logic [31:0]  crc;
        axis_byte_t   b;
        hbits = f_hdr[idx];
        crc   = `ETH_CRC_INIT;
        for (int k = 0; k < `ETH_HDR_BYTES; k++) begin
            bytes.push_back(hbits[111:104]);
            hbits = hbits << 8;
        end
        for (int k = 0; k < f_len[idx]; k++) begin
            bytes.push_back(pay_mem[f_start[idx] + k]);
        end
        while (bytes.size() < `ETH_MIN_FRAME_BYTES) begin
            bytes.push_back(8'h00);
        end
        b = '0;
        foreach (bytes[k]) begin
            crc     = crc_update(crc, bytes[k]);
            b.tdata = bytes[k];
            exp_q.push_back(b);
        end
        // fcs is the inverted crc sent low byte first
        crc = ~crc;
        for (int k = 0; k < `ETH_FCS_BYTES; k++) begin
            b.tdata = crc[7:0];
            b.tlast = (k == `ETH_FCS_BYTES - 1);
            b.tuser = b.tlast & f_bad[idx];
            exp_q.push_back(b);
            crc = crc >> 8;
        end
    endfunction

    // payload is random when rnd is set and a counting pattern otherwise
    function automatic void add_frame(input eth_hdr_t h, input int len, input logic bad,
                                      input logic rnd);
        f_hdr.push_back(h);
        f_len.push_back(len);
        f_bad.push_back(bad);
        f_start.push_back(pay_mem.size());
        for (int k = 0; k < len; k++) begin
            pay_mem.push_back(rnd ? 8'(rand_bits(8)) : 8'(3 * k + 1));
        end
    endfunction

    task automatic start_test(input string name);
        test_name = name;
        err_mark  = errors;
        byte_mark = checked;
    endtask

    task automatic end_test();
        if (errors != err_mark) begin
            tests_failed++;
        end
        $display("test %s: %0d bytes checked, %0d errors", test_name, checked - byte_mark,
                 errors - err_mark);
    endtask

    // drives headers and payloads of a frame range and returns once all output arrived
    task automatic run_frames(input int first, input int num, input logic stall);
        int   hdr_idx;
        int   pay_idx;
        int   pay_pos;
        logic hdr_fire;
        logic pay_fire;
        for (int i = first; i < first + num; i++) begin
            build_expected(i);
        end
        hdr_idx = first;
        pay_idx = first;
        pay_pos = 0;
        while (hdr_idx < first + num || pay_idx < first + num || exp_q.size() != 0) begin
            @(posedge clk);
            hdr_fire = hdr_valid && hdr_ready;
            pay_fire = s_payload_valid && s_payload_ready;
            @(negedge clk);
            if (hdr_fire) begin
                hdr_idx++;
            end
            if (pay_fire) begin
                pay_pos++;
                if (pay_pos == f_len[pay_idx]) begin
                    pay_idx++;
                    pay_pos = 0;
                end
            end
            if (!hdr_valid || hdr_fire) begin
                hdr_valid = 1'b0;
                if (hdr_idx < first + num && (!stall || rand_bits(2) != 0)) begin
                    hdr       = f_hdr[hdr_idx];
                    hdr_valid = 1'b1;
                end
            end
            if (!s_payload_valid || pay_fire) begin
                s_payload_valid = 1'b0;
                if (pay_idx < first + num && (!stall || rand_bits(2) != 0)) begin
                    s_payload.tdata = pay_mem[f_start[pay_idx] + pay_pos];
                    s_payload.tlast = (pay_pos == f_len[pay_idx] - 1);
                    s_payload.tuser = s_payload.tlast & f_bad[pay_idx];
                    s_payload_valid = 1'b1;
                end
            end
            m_frame_ready = !stall || rand_bits(1) != 0;
        end
    endtask

    // compares every accepted output byte with the model
    always @(posedge clk) begin : compare
        axis_byte_t want;
        if (!rst && m_frame_valid && m_frame_ready) begin
            assert (exp_q.size() != 0) else begin
                $display("error in %s: output byte arrived with none left to expect", test_name);
                errors++;
            end
            if (exp_q.size() != 0) begin
                want = exp_q.pop_front();
                assert (m_frame == want) else begin
                    $display("** Error: %s byte %0d expected %02h/%b/%b actual %02h/%b/%b",
                             test_name, checked - byte_mark, want.tdata, want.tlast,
                             want.tuser, m_frame.tdata, m_frame.tlast, m_frame.tuser);
                    errors++;
                end
                checked++;
            end
            frame_bytes++;
            if (m_frame.tlast) begin
                last_frame_len = frame_bytes;
                frame_bytes    = 0;
            end
        end
    end

    initial begin : watchdog
        wait (limit_cycles != 0);
        repeat (limit_cycles) @(posedge clk);
        $display("watchdog: run not finished after %0d cycles", limit_cycles);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin : main
        eth_hdr_t h;
        int       total;
        hdr             = '0;
        hdr_valid       = 1'b0;
        s_payload       = '0;
        s_payload_valid = 1'b0;
        m_frame_ready   = 1'b0;
        lfsr_state      = 16'd61;
        errors          = 0;
        checked         = 0;
        tests_failed    = 0;
        frame_bytes     = 0;
        last_frame_len  = 0;
        total           = 0;
        h.dest_mac = 48'h0A0B0C0D0E0F;
        h.src_mac  = 48'h021122334455;
        h.eth_type = 16'h0800;
        add_frame(h, 100, 1'b0, 1'b0);
        add_frame(h, 10, 1'b0, 1'b0);
        add_frame(h, 20, 1'b1, 1'b0);
        for (int i = 0; i < 10; i++) begin
            h.dest_mac = {24'(rand_bits(24)), 24'(rand_bits(24))};
            h.src_mac  = {24'(rand_bits(24)), 24'(rand_bits(24))};
            h.eth_type = 16'(rand_bits(16));
            add_frame(h, 1 + int'(rand_bits(7) % 80), 1'b0, 1'b1);
        end
        // random frames go through twice
        foreach (f_len[i]) begin
            total += (i >= 3) ? 2 * wire_bytes(f_len[i]) : wire_bytes(f_len[i]);
        end
        limit_cycles = 200 * total;

        start_test("reset_and_long_frame");
        @(negedge clk);
        assert (!hdr_ready && !s_payload_ready && !m_frame_valid && !busy) else begin
            $display("error in %s: a ready, valid or busy output was high during reset",
                     test_name);
            errors++;
        end
        wait (!rst);
        @(negedge clk);
        assert (!m_frame_valid && !busy) else begin
            $display("error in %s: m_frame_valid or busy high after reset", test_name);
            errors++;
        end
        run_frames(0, 1, 1'b0);
        end_test();

        start_test("short_frame_padding");
        run_frames(1, 1, 1'b0);
        assert (last_frame_len == `ETH_MIN_FRAME_BYTES + `ETH_FCS_BYTES) else begin
            $display("** Error: %s frame length expected %0d actual %0d", test_name,
                     `ETH_MIN_FRAME_BYTES + `ETH_FCS_BYTES, last_frame_len);
            errors++;
        end
        end_test();

        start_test("bad_frame_tuser");
        run_frames(2, 1, 1'b0);
        end_test();

        start_test("back_to_back_random");
        run_frames(3, 10, 1'b0);
        end_test();

        start_test("random_stalls");
        run_frames(3, 10, 1'b1);
        assert (!busy) else begin
            $display("error in %s: busy still high after the last frame", test_name);
            errors++;
        end
        end_test();

        $display("tests run 5, tests failed %0d, bytes checked %0d, errors %0d",
                 tests_failed, checked, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- bench/eth_tx_path_sva.sv
/* concurrent checks on the tx path handshakes, bound into eth_tx_path by the testbench */
`timescale 1ns/100ps

module eth_tx_path_sva import eth_tx_pkg::*; (
    input logic       clk,
    input logic       rst,
    input axis_byte_t s_payload,
    input logic       s_payload_valid,
    input logic       s_payload_ready,
    input axis_byte_t m_frame,
    input logic       m_frame_valid,
    input logic       m_frame_ready,
    input logic       busy
);

    // frames whose last payload byte went in while busy has not dropped yet
    logic [7:0] tlast_pending;
    logic       busy_q;
    logic       tlast_in;
    logic       busy_fell;

    assign tlast_in  = s_payload_valid && s_payload_ready && s_payload.tlast;
    assign busy_fell = busy_q && !busy;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tlast_pending <= '0;
            busy_q        <= 1'b0;
        end else begin
            busy_q <= busy;
            if (tlast_in && !busy_fell) begin
                tlast_pending <= tlast_pending + 8'd1;
            end else if (!tlast_in && busy_fell) begin
                tlast_pending <= tlast_pending - 8'd1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        m_frame_valid && !m_frame_ready |=> m_frame_valid && $stable(m_frame))
        else $error("m_frame dropped or changed while m_frame_ready was low");

    assert property (@(posedge clk) rst |=> !m_frame_valid)
        else $error("m_frame_valid high during reset");

    assert property (@(posedge clk) disable iff (rst) $fell(busy) |-> tlast_pending != 8'd0)
        else $error("busy fell before a payload tlast byte was taken in");

endmodule

//--- bench/tb_clock_gen.sv
/* clock and reset source for the testbench, 100 ns clock and reset held for 5 cycles */
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // released on a falling edge, away from the sampling edge
    initial begin
        rst = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

//--- logic/eth_tx_path.sv
/* ethernet tx path top: header and payload in, finished frame with padding
   and fcs out as a byte stream; all links use valid/ready */
`timescale 1ns/100ps

module eth_tx_path import eth_tx_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  eth_hdr_t   hdr,
    input  logic       hdr_valid,
    output logic       hdr_ready,
    input  axis_byte_t s_payload,
    input  logic       s_payload_valid,
    output logic       s_payload_ready,
    output axis_byte_t m_frame,
    output logic       m_frame_valid,
    input  logic       m_frame_ready,
    output logic       busy
);

    eth_hdr_t   hdr_q;
    logic       hdr_q_valid;
    logic       hdr_q_ready;
    axis_byte_t pay_q;
    logic       pay_q_valid;
    logic       pay_q_ready;
    axis_byte_t ser_byte;
    logic       ser_valid;
    logic       ser_ready;

    // input slices
    axis_skid_reg #(
        .T(eth_hdr_t)
    ) u_hdr_in (
        .clk      (clk),
        .rst      (rst),
        .in_data  (hdr),
        .in_valid (hdr_valid),
        .in_ready (hdr_ready),
        .out_data (hdr_q),
        .out_valid(hdr_q_valid),
        .out_ready(hdr_q_ready)
    );

    axis_skid_reg #(
        .T(axis_byte_t)
    ) u_payload_in (
        .clk      (clk),
        .rst      (rst),
        .in_data  (s_payload),
        .in_valid (s_payload_valid),
        .in_ready (s_payload_ready),
        .out_data (pay_q),
        .out_valid(pay_q_valid),
        .out_ready(pay_q_ready)
    );

    eth_hdr_serializer u_serializer (
        .clk          (clk),
        .rst          (rst),
        .hdr          (hdr_q),
        .hdr_valid    (hdr_q_valid),
        .hdr_ready    (hdr_q_ready),
        .payload      (pay_q),
        .payload_valid(pay_q_valid),
        .payload_ready(pay_q_ready),
        .out_byte     (ser_byte),
        .out_valid    (ser_valid),
        .out_ready    (ser_ready),
        .busy         (busy)
    );

    eth_fcs_insert u_fcs (
        .clk      (clk),
        .rst      (rst),
        .in_byte  (ser_byte),
        .in_valid (ser_valid),
        .in_ready (ser_ready),
        .out_byte (m_frame),
        .out_valid(m_frame_valid),
        .out_ready(m_frame_ready)
    );

endmodule

//--- logic/eth_fcs_insert.sv
/* passes frame bytes on, zero-pads short frames to the minimum length and
   appends the CRC-32 fcs lsb first; input is held off while padding or appending */
`timescale 1ns/100ps
`include "eth_tx_defines.svh"

module eth_fcs_insert import eth_tx_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  axis_byte_t in_byte,
    input  logic       in_valid,
    output logic       in_ready,
    output axis_byte_t out_byte,
    output logic       out_valid,
    input  logic       out_ready
);

    typedef enum logic [1:0] {
        ST_DATA,
        ST_PAD,
        ST_FCS
    } state_t;

    localparam logic [5:0] MIN_LEN  = 6'(`ETH_MIN_FRAME_BYTES);
    localparam logic [1:0] FCS_LAST = 2'(`ETH_FCS_BYTES - 1);

    state_t      state;
    // bytes sent so far, stops counting at the minimum length
    logic [5:0]  count;
    logic [1:0]  fcs_idx;
    logic [31:0] crc;
    logic [31:0] fcs;
    // tuser seen on any byte of the current frame
    logic        frame_bad;
    axis_byte_t  st_data;
    logic        st_valid;
    logic        st_ready;
    logic        st_xfer;

    // one byte into the reflected crc, lsb first
    function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] d);
        logic [31:0] r;
        r = c ^ {24'd0, d};
        for (int i = 0; i < 8; i++) begin
            r = r[0] ? ((r >> 1) ^ `ETH_CRC_POLY) : (r >> 1);
        end
        return r;
    endfunction

    assign fcs = ~crc;

    always_comb begin
        st_data  = '0;
        st_valid = 1'b0;
        case (state)
            ST_DATA: begin
                // tlast and tuser move to the final fcs byte
                st_data.tdata = in_byte.tdata;
                st_valid      = in_valid;
            end
            ST_PAD: begin
                st_valid = 1'b1;
            end
            ST_FCS: begin
                st_data.tdata = fcs[8 * fcs_idx +: 8];
                st_data.tlast = (fcs_idx == FCS_LAST);
                st_data.tuser = (fcs_idx == FCS_LAST) && frame_bad;
                st_valid      = 1'b1;
            end
            default: begin
                st_valid = 1'b0;
            end
        endcase
    end

    assign in_ready = (state == ST_DATA) && st_ready;
    assign st_xfer  = st_valid && st_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= ST_DATA;
            count     <= '0;
            fcs_idx   <= '0;
            crc       <= `ETH_CRC_INIT;
            frame_bad <= 1'b0;
        end else if (st_xfer) begin
            case (state)
                ST_DATA: begin
                    crc       <= crc_byte(crc, in_byte.tdata);
                    frame_bad <= frame_bad | in_byte.tuser;
                    if (count != MIN_LEN) begin
                        count <= count + 6'd1;
                    end
                    if (in_byte.tlast) begin
                        state <= (count >= MIN_LEN - 6'd1) ? ST_FCS : ST_PAD;
                    end
                end
                ST_PAD: begin
                    crc   <= crc_byte(crc, 8'h00);
                    count <= count + 6'd1;
                    if (count == MIN_LEN - 6'd1) begin
                        state <= ST_FCS;
                    end
                end
                ST_FCS: begin
                    fcs_idx <= fcs_idx + 2'd1;
                    // frame done, start fresh for the next one
                    if (fcs_idx == FCS_LAST) begin
                        state     <= ST_DATA;
                        count     <= '0;
                        crc       <= `ETH_CRC_INIT;
                        frame_bad <= 1'b0;
                    end
                end
                default: begin
                    state <= ST_DATA;
                end
            endcase
        end
    end

    axis_skid_reg #(
        .T(axis_byte_t)
    ) u_out_reg (
        .clk      (clk),
        .rst      (rst),
        .in_data  (st_data),
        .in_valid (st_valid),
        .in_ready (st_ready),
        .out_data (out_byte),
        .out_valid(out_valid),
        .out_ready(out_ready)
    );

endmodule

//--- logic/eth_hdr_serializer.sv
/* takes one parallel header, sends its 14 bytes msb first and then forwards
   the payload stream up to and including its tlast byte */
`timescale 1ns/100ps
`include "eth_tx_defines.svh"

module eth_hdr_serializer import eth_tx_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  eth_hdr_t   hdr,
    input  logic       hdr_valid,
    output logic       hdr_ready,
    input  axis_byte_t payload,
    input  logic       payload_valid,
    output logic       payload_ready,
    output axis_byte_t out_byte,
    output logic       out_valid,
    input  logic       out_ready,
    output logic       busy
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HEADER,
        ST_PAYLOAD
    } state_t;

    localparam logic [3:0] HDR_LAST = 4'(`ETH_HDR_BYTES - 1);

    state_t     state;
    // index of the next header byte
    logic [3:0] ptr;
    eth_hdr_t   hdr_q;
    axis_byte_t ser_data;
    logic       ser_valid;
    logic       ser_ready;

    always_comb begin
        ser_data  = '0;
        ser_valid = 1'b0;
        case (state)
            ST_HEADER: begin
                // byte 0 is the top byte of dest_mac
                ser_data.tdata = hdr_q[8 * (HDR_LAST - ptr) +: 8];
                ser_valid      = 1'b1;
            end
            ST_PAYLOAD: begin
                ser_data  = payload;
                ser_valid = payload_valid;
            end
            default: begin
                ser_valid = 1'b0;
            end
        endcase
    end

    assign hdr_ready     = (state == ST_IDLE);
    assign payload_ready = (state == ST_PAYLOAD) && ser_ready;
    assign busy          = (state != ST_IDLE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_IDLE;
            ptr   <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    ptr <= '0;
                    if (hdr_valid) begin
                        state <= ST_HEADER;
                    end
                end
                ST_HEADER: begin
                    if (ser_ready) begin
                        ptr <= ptr + 4'd1;
                        if (ptr == HDR_LAST) begin
                            state <= ST_PAYLOAD;
                        end
                    end
                end
                ST_PAYLOAD: begin
                    // back to idle once the tlast byte is handed on
                    if (payload_valid && ser_ready && payload.tlast) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // header is held for the whole header phase
    always_ff @(posedge clk) begin
        if (hdr_valid && hdr_ready) begin
            hdr_q <= hdr;
        end
    end

    axis_skid_reg #(
        .T(axis_byte_t)
    ) u_out_reg (
        .clk      (clk),
        .rst      (rst),
        .in_data  (ser_data),
        .in_valid (ser_valid),
        .in_ready (ser_ready),
        .out_data (out_byte),
        .out_valid(out_valid),
        .out_ready(out_ready)
    );

endmodule

//--- logic/axis_skid_reg.sv
/* registered valid/ready slice with a spare entry, so in_ready can be a flop;
   T selects the payload carried through it */
`timescale 1ns/100ps

module axis_skid_reg import eth_tx_pkg::*; #(
    parameter type T = axis_byte_t
) (
    input  logic clk,
    input  logic rst,
    input  T     in_data,
    input  logic in_valid,
    output logic in_ready,
    output T     out_data,
    output logic out_valid,
    input  logic out_ready
);

    T     temp_data;
    logic temp_valid;
    logic in_xfer;
    logic ready_early;
    logic load_out;
    logic load_temp;
    logic temp_to_out;

    assign in_xfer = in_valid && in_ready;

    // next-cycle ready: output drains, or temp stays free after this cycle
    assign ready_early = out_ready || (!temp_valid && (!out_valid || !in_xfer));

    // input goes straight to the output register when that one frees up
    assign load_out    = in_ready && (out_ready || !out_valid);
    // output stalled, park the incoming item in temp
    assign load_temp   = in_xfer && out_valid && !out_ready;
    assign temp_to_out = !in_ready && out_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            in_ready   <= 1'b0;
            out_valid  <= 1'b0;
            temp_valid <= 1'b0;
        end else begin
            in_ready <= ready_early;
            if (load_out) begin
                out_valid <= in_valid;
            end else if (load_temp) begin
                temp_valid <= 1'b1;
            end else if (temp_to_out) begin
                out_valid  <= temp_valid;
                temp_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_out) begin
            out_data <= in_data;
        end else if (temp_to_out) begin
            out_data <= temp_data;
        end
        if (load_temp) begin
            temp_data <= in_data;
        end
    end

endmodule

//--- logic/eth_tx_pkg.sv
/* types shared by the ethernet tx datapath and its testbench */
package eth_tx_pkg;

    // parallel frame header, dest_mac is sent first on the wire
    typedef struct packed {
        logic [47:0] dest_mac;
        logic [47:0] src_mac;
        logic [15:0] eth_type;
    } eth_hdr_t;

    // one beat of a byte stream
    typedef struct packed {
        logic [7:0] tdata;
        // last byte of the frame
        logic       tlast;
        // frame marked bad
        logic       tuser;
    } axis_byte_t;

endpackage

//--- logic/eth_tx_defines.svh
/* ethernet framing constants for the tx datapath and its testbench;
   include wherever frame lengths or the CRC-32 constants are needed */
`ifndef ETH_TX_DEFINES_SVH
`define ETH_TX_DEFINES_SVH

// dest mac + src mac + ethertype
`define ETH_HDR_BYTES        14

// shortest frame without the fcs, shorter ones get zero padding
`define ETH_MIN_FRAME_BYTES  60

`define ETH_FCS_BYTES        4

// reflected form, data is shifted in lsb first
`define ETH_CRC_POLY         32'hEDB88320
`define ETH_CRC_INIT         32'hFFFFFFFF

`endif
